// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       := approx_div_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+logic
logic/approx_div_pkg.sv
logic/div_operand_capture.sv
logic/approx_div_array.sv
logic/div_result_stage.sv
logic/approx_div_top.sv
verification/approx_div_tb.sv

// ==== logic/approx_div_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "approx_div_macros.svh"

module approx_div_array #(
  parameter int APPROX_DEPTH = `DIV_APPROX_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cap_valid,
  input  approx_div_pkg::dividend_t  cap_n,
  input  approx_div_pkg::divisor_t   cap_d,
  input  logic                       cap_ovf,
  output logic                       arr_valid,
  output approx_div_pkg::quotient_t  arr_q,
  output approx_div_pkg::remainder_t arr_r,
  output logic                       arr_ovf
);

  import approx_div_pkg::*;

  quotient_t  quo_c;
  remainder_t rem_c;

  // ******************************
  // Restoring array
  // ******************************

  // Row i produces quotient bit i, column j subtracts divisor bit j.
  // Row 7 works on the top dividend bits, every lower row takes the
  // shifted partial remainder of the row above plus one new dividend bit.
  for (genvar i = 0; i < 8; i++) begin : g_row
    wire qb;   // Quotient bit of this row

    for (genvar j = 0; j < 8; j++) begin : g_col
      wire x;    // Minuend bit
      wire bi;   // Borrow in
      wire bo;   // Borrow out
      wire df;   // Difference
      wire ro;   // Restored output

      if (j == 0) begin : g_lsb
        assign x  = cap_n[i];   // New dividend bit enters here
        assign bi = 1'b0;
      end else if (i == 7) begin : g_top
        assign x  = cap_n[7 + j];
        assign bi = g_col[j - 1].bo;
      end else begin : g_mid
        assign x  = g_row[i + 1].g_col[j - 1].ro;
        assign bi = g_col[j - 1].bo;
      end

      if (i + j < APPROX_DEPTH) begin : g_apx
        // Borrow chain cut, divisor bit ignored
        assign bo = 1'b0;
        assign df = x & ~bi;
      end else begin : g_exa
        assign bo = (~x & cap_d[j]) | (~(x ^ cap_d[j]) & bi);
        assign df = x ^ cap_d[j] ^ bi;
      end

      assign ro = qb ? df : x;   // Keep minuend when subtraction fails
    end

    if (i == 7) begin : g_qtop
      assign qb = cap_n[15] | ~g_col[7].bo;
    end else begin : g_qmid
      assign qb = g_row[i + 1].g_col[7].ro | ~g_col[7].bo;
    end
  end

  for (genvar k = 0; k < 8; k++) begin : g_out
    assign quo_c[k] = g_row[k].qb;
    assign rem_c[k] = g_row[0].g_col[k].ro;   // Remainder leaves row 0
  end

  // ******************************
  // Pipeline register
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arr_valid <= 1'b0;
    end else begin
      arr_valid <= cap_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cap_valid) begin
      arr_q   <= quo_c;
      arr_r   <= rem_c;
      arr_ovf <= cap_ovf;   // Forwarded for saturation downstream
    end
  end

  // One cycle through the array, never dropped or repeated
  a_valid_follow: assert property (
    @(posedge clk) disable iff (!rst_n)
    arr_valid == $past(cap_valid)
  );

endmodule : approx_div_array

`default_nettype wire

// ==== logic/approx_div_macros.svh ====
`ifndef APPROX_DIV_MACROS_SVH
`define APPROX_DIV_MACROS_SVH

// ******************************
// Approximation corner
// ******************************

// Cell (row i, column j) is approximate when i + j is below this value
`define DIV_APPROX_DEPTH 4

// ******************************
// Overflow result
// ******************************

`define DIV_SAT_QUOTIENT  8'hFF
`define DIV_SAT_REMAINDER 8'h00

`endif

// ==== logic/approx_div_pkg.sv ====
`default_nettype none

package approx_div_pkg;

  // ******************************
  // Operand and result widths
  // ******************************

  // Unsigned dividend, upper byte must stay below the divisor
  typedef logic [15:0] dividend_t;

  // Unsigned divisor
  typedef logic [7:0] divisor_t;

  // One quotient bit per array row
  typedef logic [7:0] quotient_t;

  // Partial remainder leaving the last row
  typedef logic [7:0] remainder_t;

endpackage : approx_div_pkg

`default_nettype wire

// ==== logic/approx_div_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module approx_div_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  approx_div_pkg::dividend_t  n,
  input  approx_div_pkg::divisor_t   d,
  output logic                       done,
  output approx_div_pkg::quotient_t  q,
  output approx_div_pkg::remainder_t r,
  output logic                       ovf
);

  import approx_div_pkg::*;

  // Capture to array
  logic       cap_valid;
  dividend_t  cap_n;
  divisor_t   cap_d;
  logic       cap_ovf;

  // Array to result
  logic       arr_valid;
  quotient_t  arr_q;
  remainder_t arr_r;
  logic       arr_ovf;

  div_operand_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .n         (n),
    .d         (d),
    .cap_valid (cap_valid),
    .cap_n     (cap_n),
    .cap_d     (cap_d),
    .cap_ovf   (cap_ovf)
  );

  approx_div_array u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .cap_valid (cap_valid),
    .cap_n     (cap_n),
    .cap_d     (cap_d),
    .cap_ovf   (cap_ovf),
    .arr_valid (arr_valid),
    .arr_q     (arr_q),
    .arr_r     (arr_r),
    .arr_ovf   (arr_ovf)
  );

  div_result_stage u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .arr_valid (arr_valid),
    .arr_q     (arr_q),
    .arr_r     (arr_r),
    .arr_ovf   (arr_ovf),
    .done      (done),
    .q         (q),
    .r         (r),
    .ovf       (ovf)
  );

endmodule : approx_div_top

`default_nettype wire

// ==== logic/div_operand_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_operand_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  approx_div_pkg::dividend_t n,
  input  approx_div_pkg::divisor_t  d,
  output logic                      cap_valid,
  output approx_div_pkg::dividend_t cap_n,
  output approx_div_pkg::divisor_t  cap_d,
  output logic                      cap_ovf
);

  import approx_div_pkg::*;

  divisor_t n_hi;   // Upper dividend byte
  logic     ovf_c;

  assign n_hi  = n[15:8];
  assign ovf_c = (n_hi >= d);   // Quotient would not fit, covers d == 0

  // ******************************
  // Valid flag
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= start;
    end
  end

  // ******************************
  // Operand registers
  // ******************************

  always_ff @(posedge clk) begin
    if (start) begin
      cap_n   <= n;
      cap_d   <= d;
      cap_ovf <= ovf_c;
    end
  end

  // A zero divisor must never reach the array as a normal operation
  a_zero_div_ovf: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cap_valid && (cap_d == '0)) |-> cap_ovf
  );

endmodule : div_operand_capture

`default_nettype wire

// ==== logic/div_result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "approx_div_macros.svh"

module div_result_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       arr_valid,
  input  approx_div_pkg::quotient_t  arr_q,
  input  approx_div_pkg::remainder_t arr_r,
  input  logic                       arr_ovf,
  output logic                       done,
  output approx_div_pkg::quotient_t  q,
  output approx_div_pkg::remainder_t r,
  output logic                       ovf
);

  import approx_div_pkg::*;

  quotient_t  q_next;
  remainder_t r_next;

  // Overflowed results are replaced by fixed values
  assign q_next = arr_ovf ? `DIV_SAT_QUOTIENT : arr_q;
  assign r_next = arr_ovf ? `DIV_SAT_REMAINDER : arr_r;

  // ******************************
  // Output registers
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
      q    <= '0;
      r    <= '0;
      ovf  <= 1'b0;
    end else begin
      done <= arr_valid;   // Single cycle strobe per result
      if (arr_valid) begin
        q   <= q_next;
        r   <= r_next;
        ovf <= arr_ovf;
      end
    end
  end

  // Back to back done only for back to back results
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    (done && $past(done)) |-> ($past(arr_valid) && $past(arr_valid, 2))
  );

endmodule : div_result_stage

`default_nettype wire

// ==== verification/approx_div_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "approx_div_macros.svh"

module approx_div_tb;

  import approx_div_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int N_DIRECTED      = 12;
  localparam int N_OVERFLOW      = 5;
  localparam int N_STREAM        = 200;
  localparam int N_GAP           = 150;
  localparam int TOTAL_STARTS    = N_DIRECTED + N_OVERFLOW + N_STREAM + N_GAP;
  localparam int WATCHDOG_CYCLES = TOTAL_STARTS * 4 + 200;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       start;
  dividend_t  n;
  divisor_t   d;
  logic       done;
  quotient_t  q;
  remainder_t r;
  logic       ovf;

  int          cyc = 0;
  logic [31:0] rng_state = 32'h4652_5ac5;
  string       cur_test = "reset";

  // Expected results in start order
  logic [16:0] exp_q[$];
  int          exp_cyc[$];
  string       exp_name[$];

  int checks = 0;
  int value_errors = 0;
  int timing_errors = 0;
  int protocol_errors = 0;

  approx_div_top UUT (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .n     (n),
    .d     (d),
    .done  (done),
    .q     (q),
    .r     (r),
    .ovf   (ovf)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;   // Cycle index seen at negedge

  // ******************************
  // Reference model
  // ******************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Returns {ovf, quotient, remainder}
  function automatic logic [16:0] ref_divide(input logic [15:0] nv, input logic [7:0] dv,
                                             input int depth);
    logic [7:0] prev_ro;
    logic [7:0] x;
    logic [7:0] bo;
    logic [7:0] df;
    logic [7:0] qv;
    logic       bin;
    logic       hi;
    logic       qb;
    int         i;
    int         j;
    if (nv[15:8] >= dv) begin
      return {1'b1, `DIV_SAT_QUOTIENT, `DIV_SAT_REMAINDER};
    end
    prev_ro = 8'h00;
    qv      = 8'h00;
    x       = 8'h00;
    bo      = 8'h00;
    df      = 8'h00;
    for (i = 7; i >= 0; i--) begin
      for (j = 0; j < 8; j++) begin
        if (j == 0) begin
          x[j] = nv[i];   // New dividend bit
        end else if (i == 7) begin
          x[j] = nv[7 + j];
        end else begin
          x[j] = prev_ro[j - 1];   // Shifted remainder of the row above
        end
        bin = (j == 0) ? 1'b0 : bo[j - 1];
        if (i + j < depth) begin
          bo[j] = 1'b0;
          df[j] = x[j] & ~bin;
        end else begin
          df[j] = x[j] ^ dv[j] ^ bin;
          bo[j] = (~x[j] & dv[j]) | ((x[j] == dv[j]) & bin);
        end
      end
      hi      = (i == 7) ? nv[15] : prev_ro[7];
      qb      = hi | ~bo[7];
      qv[i]   = qb;
      prev_ro = qb ? df : x;
    end
    return {1'b0, qv, prev_ro};
  endfunction

  // ******************************
  // Compare process
  // ******************************

  always @(negedge clk) begin : compare
    logic [16:0] want;
    int          want_cyc;
    string       name;
    if (rst_n) begin
      if ((exp_q.size() != 0) && (cyc > exp_cyc[0] + 3)) begin
        $display("No done seen for the %s operation started in cycle %0d",
                 exp_name[0], exp_cyc[0]);
        protocol_errors++;
        want     = exp_q.pop_front();
        want_cyc = exp_cyc.pop_front();
        name     = exp_name.pop_front();
      end
      if (done) begin
        if (exp_q.size() == 0) begin
          $display("Done strobe in cycle %0d with no operation outstanding", cyc);
          protocol_errors++;
        end else begin
          want     = exp_q.pop_front();
          want_cyc = exp_cyc.pop_front();
          name     = exp_name.pop_front();
          checks++;
          if (q !== want[15:8]) begin
            $display("FAILED %s: q expected %h actual %h", name, want[15:8], q);
            value_errors++;
          end
          if (r !== want[7:0]) begin
            $display("FAILED %s: r expected %h actual %h", name, want[7:0], r);
            value_errors++;
          end
          if (ovf !== want[16]) begin
            $display("FAILED %s: ovf expected %b actual %b", name, want[16], ovf);
            value_errors++;
          end
          if (cyc != want_cyc + 3) begin
            $display("FAILED %s: done cycle expected %0d actual %0d", name, want_cyc + 3, cyc);
            timing_errors++;
          end
        end
      end
      if (start) begin
        exp_q.push_back(ref_divide(n, d, `DIV_APPROX_DEPTH));
        exp_cyc.push_back(cyc);
        exp_name.push_back(cur_test);
      end
    end
  end

  // ******************************
  // Stimulus
  // ******************************

  task automatic start_op(input dividend_t nv, input divisor_t dv);
    @(posedge clk);
    start <= 1'b1;
    n     <= nv;
    d     <= dv;
  endtask

  task automatic idle_cycles(input int cnt);
    repeat (cnt) begin
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  task automatic pick_operands(output dividend_t nv, output divisor_t dv);
    logic [31:0] rnd;
    rng_state = xorshift32(rng_state);
    rnd       = rng_state;
    dv        = rnd[7:0];
    nv        = rnd[31:16];
    if (rnd[8] && (dv != 8'd0)) begin
      nv[15:8] = rnd[31:24] % dv;   // Pull into the non-overflow range
    end
  endtask

  initial begin : stimulus
    dividend_t nv;
    divisor_t  dv;
    int        gap;
    int        total;
    rst_n = 1'b0;
    start = 1'b0;
    n     = '0;
    d     = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "idle";
    repeat (5) begin
      @(negedge clk);
      if ((done !== 1'b0) || (q !== 8'h00) || (r !== 8'h00) || (ovf !== 1'b0)) begin
        $display("FAILED idle: done,q,r,ovf expected 0,00,00,0 actual %b,%h,%h,%b",
                 done, q, r, ovf);
        value_errors++;
      end
    end

    cur_test = "directed";
    start_op(16'h0000, 8'h01);
    start_op(16'h0001, 8'h03);
    start_op(16'h0007, 8'h02);
    start_op(16'h0064, 8'h0A);
    start_op(16'h09FF, 8'h0A);   // Just below the overflow boundary
    start_op(16'hFEFF, 8'hFF);
    start_op(16'h7F80, 8'h80);
    start_op(16'h00FF, 8'h01);
    start_op(16'h00AB, 8'h01);   // Low divisor bits only
    start_op(16'h0123, 8'h03);
    start_op(16'h0456, 8'h07);
    start_op(16'h0ABC, 8'h0F);
    idle_cycles(4);

    cur_test = "overflow";
    start_op(16'h0A00, 8'h0A);
    start_op(16'hFFFF, 8'h00);   // Zero divisor
    start_op(16'h0000, 8'h00);
    start_op(16'h8000, 8'h7F);
    start_op(16'hFF00, 8'hFF);
    idle_cycles(4);

    cur_test = "stream";
    for (int k = 0; k < N_STREAM; k++) begin
      pick_operands(nv, dv);
      start_op(nv, dv);
    end
    idle_cycles(4);

    cur_test = "gaps";
    for (int k = 0; k < N_GAP; k++) begin
      pick_operands(nv, dv);
      start_op(nv, dv);
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state[1:0]);
      idle_cycles(gap);
    end
    idle_cycles(1);

    while (exp_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);   // Catch late or extra done strobes

    total = value_errors + timing_errors + protocol_errors;
    $display("Summary: %0d results, %0d value errors, %0d timing errors, %0d protocol errors",
             checks, value_errors, timing_errors, protocol_errors);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // ******************************
  // Watchdog
  // ******************************

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, %0d results still outstanding",
             WATCHDOG_CYCLES, exp_q.size());
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : approx_div_tb

`default_nettype wire
